//--- Makefile
VERILATOR ?= verilator
TOP       ?= hazardUnitTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/hazardGolden.txt
# name  instrD(hex)  stall  fwdRsD fwdRtD fwdRsE fwdRtE fwdRtM
# select codes: 0 none, 1 E, 2 M, 3 W
reset       00000000 0 0 0 0 0 0
reset       00000000 0 0 0 0 0 0
reset       00000000 0 0 0 0 0 0
aluChain    00221820 0 0 0 0 0 0
aluChain    00652022 0 0 0 0 0 0
aluChain    00000000 0 0 0 2 0 0
aluApart    00223020 0 0 0 0 0 0
aluApart    00000000 0 0 0 0 0 0
aluApart    00c83822 0 2 0 0 0 0
aluApart    00000000 0 0 0 3 0 0
loadUse     8d490000 0 0 0 0 0 0
loadUse     01215820 1 0 0 0 0 0
loadUse     01215820 0 0 0 0 0 0
loadUse     00000000 0 0 0 3 0 0
branchStall 200c0005 0 0 0 0 0 0
branchStall 11810004 1 0 0 0 0 0
branchStall 11810004 0 2 0 0 0 0
jalJr       0c000100 0 0 0 3 0 0
jalJr       03e00008 0 1 0 0 0 0
jalJr       00000000 0 0 0 2 0 0
loadStore   8c2d0000 0 0 0 0 0 0
loadStore   ac4d0004 0 0 0 0 0 0
loadStore   00000000 0 0 0 0 0 0
loadStore   00000000 0 0 0 0 0 3
zeroReg     8c200000 0 0 0 0 0 0
zeroReg     00007820 0 0 0 0 0 0
zeroReg     00000000 0 0 0 0 0 0
zeroReg     00000000 0 0 0 0 0 0
drain       00000000 0 0 0 0 0 0

//--- bench/hazardUnitTb.sv
`timescale 1ns/100ps

module hazardUnitTb;

	localparam int clkPeriod   = 8;
	localparam int resetCycles = 8;
	localparam int driveDelay  = 1;
	// One ns before the next rising edge
	localparam int sampleDelay = clkPeriod - driveDelay - 1;
	localparam int maxVectors  = 64;
	localparam int slackCycles = 20;

	// beq $1, $2 sits in D while the stage records are held in reset
	localparam logic [31:0] resetInstr = 32'h10220000;

	logic             clk;
	logic             rstN;
	logic [31:0]      instrD;
	logic             stall;
	hazardPkg::fwdSrc fwdRsD;
	hazardPkg::fwdSrc fwdRtD;
	hazardPkg::fwdSrc fwdRsE;
	hazardPkg::fwdSrc fwdRtE;
	hazardPkg::fwdSrc fwdRtM;

	// Golden vectors, one entry per cycle
	string            testName [maxVectors];
	logic [31:0]      instrVec [maxVectors];
	logic             expStall [maxVectors];
	hazardPkg::fwdSrc expSel   [maxVectors][5];
	int               vecCount   = 0;

	int errCount   = 0;
	int stallErrs  = 0;
	int fwdErrs    = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;

	hazardUnit hazardUnit_i (
		.clk    (clk),
		.rstN   (rstN),
		.instrD (instrD),
		.stall  (stall),
		.fwdRsD (fwdRsD),
		.fwdRtD (fwdRtD),
		.fwdRsE (fwdRsE),
		.fwdRtE (fwdRtE),
		.fwdRtM (fwdRtM)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Watchdog
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Run did not finish within %0d cycles", cycleLimit);
			$display("Verification failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Golden file and compare tasks
	////////////////////////////////////////////////////////////

	task automatic loadGolden();
		int          fd;
		int          got;
		int          fields;
		int          j;
		string       lineText;
		string       nameTok;
		logic [31:0] instrTok;
		int          stallTok;
		int          sel [5];
		fd = $fopen("bench/hazardGolden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open bench/hazardGolden.txt for reading");
		end else begin
			while (!$feof(fd) && vecCount < maxVectors) begin
				got = $fgets(lineText, fd);
				// Comment and blank lines never give all eight fields
				fields = $sscanf(lineText, "%s %h %d %d %d %d %d %d", nameTok, instrTok,
					stallTok, sel[0], sel[1], sel[2], sel[3], sel[4]);
				if (got > 0 && fields == 8) begin
					testName[vecCount] = nameTok;
					instrVec[vecCount] = instrTok;
					expStall[vecCount] = (stallTok != 0);
					for (j = 0; j < 5; j++) begin
						expSel[vecCount][j] = hazardPkg::fwdSrc'(sel[j][1:0]);
					end
					vecCount++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic checkStall(input string name, input int idx, input logic expVal,
			input logic actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errCount++;
			stallErrs++;
			$display("ERROR %s vector %0d stall: expected %b actual %b",
				name, idx, expVal, actVal);
		end
	endtask

	task automatic checkFwd(input string name, input int idx, input string selName,
			input hazardPkg::fwdSrc expVal, input hazardPkg::fwdSrc actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errCount++;
			fwdErrs++;
			$display("ERROR %s vector %0d %s: expected %s (%b) actual %s (%b)",
				name, idx, selName, expVal.name(), expVal, actVal.name(), actVal);
		end
	endtask

	task automatic checkVector(input int idx);
		checkStall(testName[idx], idx, expStall[idx], stall);
		checkFwd(testName[idx], idx, "fwdRsD", expSel[idx][0], fwdRsD);
		checkFwd(testName[idx], idx, "fwdRtD", expSel[idx][1], fwdRtD);
		checkFwd(testName[idx], idx, "fwdRsE", expSel[idx][2], fwdRsE);
		checkFwd(testName[idx], idx, "fwdRtE", expSel[idx][3], fwdRtE);
		checkFwd(testName[idx], idx, "fwdRtM", expSel[idx][4], fwdRtM);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int i;
		rstN   = 1'b0;
		instrD = resetInstr;
		loadGolden();
		if (vecCount == 0) begin
			$display("No test vectors were read from the golden file");
			$display("Verification failed");
		end else begin
			cycleLimit = resetCycles + vecCount + slackCycles;
			repeat (resetCycles) @(posedge clk);
			#driveDelay;
			rstN   = 1'b1;
			instrD = '0;
			// Stalled instructions are repeated in the file, so D holds them
			for (i = 0; i < vecCount; i++) begin
				@(posedge clk);
				#driveDelay;
				instrD = instrVec[i];
				#sampleDelay;
				checkVector(i);
			end
			$display("Checks %0d, errors %0d (stall %0d, select %0d)",
				checkCount, errCount, stallErrs, fwdErrs);
			if (errCount == 0) begin
				$display("Verification passed");
			end else begin
				$display("Verification failed");
			end
		end
		$finish;
	end

endmodule

//--- bench/hazardUnit_props.sv
`timescale 1ns/100ps

module hazardUnit_props (
	input logic                clk,
	input logic                rstN,
	input logic                stall,
	input hazardPkg::hazardRec recE,
	input hazardPkg::hazardRec recM,
	input hazardPkg::hazardRec recW,
	input hazardPkg::fwdSrc    fwdRsD,
	input hazardPkg::fwdSrc    fwdRtD,
	input hazardPkg::fwdSrc    fwdRsE,
	input hazardPkg::fwdSrc    fwdRtE,
	input hazardPkg::fwdSrc    fwdRtM
);

	// Named stage already holds its result
	function automatic logic srcReady(input hazardPkg::fwdSrc sel);
		logic ready;
		case (sel)
			hazardPkg::fwdE: ready = (recE.tnew == hazardPkg::tnewNow);
			hazardPkg::fwdM: ready = (recM.tnew == hazardPkg::tnewNow);
			hazardPkg::fwdW: ready = (recW.tnew == hazardPkg::tnewNow);
			default:         ready = 1'b1;
		endcase
		return ready;
	endfunction

	// Stage records are bubbles throughout reset
	assert property (@(posedge clk) !rstN |-> !stall)
		else $error("stall is high while reset is asserted");

	assert property (@(posedge clk) disable iff (!rstN)
		stall |=> (recE == hazardPkg::bubbleRec))
		else $error("recE is not a bubble in the cycle after a stall");

	////////////////////////////////////////////////////////////
	// Selects only point at finished results
	////////////////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!rstN) srcReady(fwdRsD))
		else $error("fwdRsD selects a stage whose result is not ready");
	assert property (@(posedge clk) disable iff (!rstN) srcReady(fwdRtD))
		else $error("fwdRtD selects a stage whose result is not ready");
	assert property (@(posedge clk) disable iff (!rstN) srcReady(fwdRsE))
		else $error("fwdRsE selects a stage whose result is not ready");
	assert property (@(posedge clk) disable iff (!rstN) srcReady(fwdRtE))
		else $error("fwdRtE selects a stage whose result is not ready");
	assert property (@(posedge clk) disable iff (!rstN) srcReady(fwdRtM))
		else $error("fwdRtM selects a stage whose result is not ready");

endmodule

// Top level sees both the stage pipe records and the resolver outputs
bind hazardUnit hazardUnit_props hazardUnitProps_i (
	.clk    (clk),
	.rstN   (rstN),
	.stall  (stall),
	.recE   (recE),
	.recM   (recM),
	.recW   (recW),
	.fwdRsD (fwdRsD),
	.fwdRtD (fwdRtD),
	.fwdRsE (fwdRsE),
	.fwdRtE (fwdRtE),
	.fwdRtM (fwdRtM)
);

//--- design/hazardDecode.sv
`timescale 1ns/100ps

module hazardDecode (
	input  mipsIsaPkg::instrFields instr,
	output hazardPkg::hazardRec    rec
);

	always_comb begin
		// Start from a slot that writes nothing and reads nothing
		rec.dest   = '0;
		rec.tnew   = hazardPkg::tnewNow;
		rec.rs     = instr.rs;
		rec.rt     = instr.rt;
		rec.tuseRs = hazardPkg::tuseNone;
		rec.tuseRt = hazardPkg::tuseNone;

		case (instr.op)
			mipsIsaPkg::opR: begin
				case (instr.funct)
					mipsIsaPkg::fnAdd, mipsIsaPkg::fnSub, mipsIsaPkg::fnAnd,
					mipsIsaPkg::fnOr, mipsIsaPkg::fnSlt, mipsIsaPkg::fnSltu: begin
						rec.dest   = instr.rd;
						rec.tnew   = hazardPkg::tnewAlu;
						rec.tuseRs = hazardPkg::tuseAlu;
						rec.tuseRt = hazardPkg::tuseAlu;
					end
					mipsIsaPkg::fnJr: begin
						// Target needed in D
						rec.tuseRs = hazardPkg::tuseBranch;
					end
					mipsIsaPkg::fnMult, mipsIsaPkg::fnMultu,
					mipsIsaPkg::fnDiv, mipsIsaPkg::fnDivu: begin
						// Result goes to HI/LO only
						rec.tuseRs = hazardPkg::tuseAlu;
						rec.tuseRt = hazardPkg::tuseAlu;
					end
					mipsIsaPkg::fnMfhi, mipsIsaPkg::fnMflo: begin
						rec.dest = instr.rd;
						rec.tnew = hazardPkg::tnewAlu;
					end
					mipsIsaPkg::fnMthi, mipsIsaPkg::fnMtlo: begin
						rec.tuseRs = hazardPkg::tuseAlu;
					end
					default: begin
						// nop and anything unlisted stay empty
					end
				endcase
			end

			// Immediate ALU ops write rt
			mipsIsaPkg::opOri, mipsIsaPkg::opAddi, mipsIsaPkg::opAndi: begin
				rec.dest   = instr.rt;
				rec.tnew   = hazardPkg::tnewAlu;
				rec.tuseRs = hazardPkg::tuseAlu;
			end

			mipsIsaPkg::opLui: begin
				rec.dest = instr.rt;
				rec.tnew = hazardPkg::tnewAlu;
			end

			// Loaded data appears after M
			mipsIsaPkg::opLw, mipsIsaPkg::opLb, mipsIsaPkg::opLh: begin
				rec.dest   = instr.rt;
				rec.tnew   = hazardPkg::tnewLoad;
				rec.tuseRs = hazardPkg::tuseAlu;
			end

			// Address in E, store data not until M
			mipsIsaPkg::opSw, mipsIsaPkg::opSb, mipsIsaPkg::opSh: begin
				rec.tuseRs = hazardPkg::tuseAlu;
				rec.tuseRt = hazardPkg::tuseStore;
			end

			// Return address is known as soon as E
			mipsIsaPkg::opJal: begin
				rec.dest = mipsIsaPkg::regRa;
				rec.tnew = hazardPkg::tnewNow;
			end

			mipsIsaPkg::opBeq, mipsIsaPkg::opBne: begin
				rec.tuseRs = hazardPkg::tuseBranch;
				rec.tuseRt = hazardPkg::tuseBranch;
			end

			// j and anything unlisted stay empty
			default: begin
			end
		endcase
	end

endmodule

//--- design/hazardPkg.sv
package hazardPkg;

	////////////////////////////////////////////////////////////
	// Stage counts
	////////////////////////////////////////////////////////////

	// Shared by Tnew and Tuse
	typedef logic [1:0] tickCount;

	// Operand not read at all
	localparam tickCount tuseNone   = 2'd3;

	// Read points, counted from D
	localparam tickCount tuseBranch = 2'd0;
	localparam tickCount tuseAlu    = 2'd1;
	localparam tickCount tuseStore  = 2'd2;

	// Result ready points, counted from E
	localparam tickCount tnewNow    = 2'd0;
	localparam tickCount tnewAlu    = 2'd1;
	localparam tickCount tnewLoad   = 2'd2;

	////////////////////////////////////////////////////////////
	// Forwarding source select
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		fwdNone = 2'd0,
		fwdE    = 2'd1,
		fwdM    = 2'd2,
		fwdW    = 2'd3
	} fwdSrc;

	////////////////////////////////////////////////////////////
	// Per-stage hazard record
	////////////////////////////////////////////////////////////

	typedef struct packed {
		mipsIsaPkg::regNum dest;
		tickCount          tnew;
		mipsIsaPkg::regNum rs;
		mipsIsaPkg::regNum rt;
		tickCount          tuseRs;
		tickCount          tuseRt;
	} hazardRec;

	// Empty slot, writes nothing and reads nothing
	localparam hazardRec bubbleRec = '{
		dest:   5'd0,
		tnew:   2'd0,
		rs:     5'd0,
		rt:     5'd0,
		tuseRs: tuseNone,
		tuseRt: tuseNone
	};

endpackage

//--- design/hazardResolve.sv
`timescale 1ns/100ps

module hazardResolve (
	input  hazardPkg::hazardRec recD,
	input  hazardPkg::hazardRec recE,
	input  hazardPkg::hazardRec recM,
	input  hazardPkg::hazardRec recW,
	output logic                stall,
	output hazardPkg::fwdSrc    fwdRsD,
	output hazardPkg::fwdSrc    fwdRtD,
	output hazardPkg::fwdSrc    fwdRsE,
	output hazardPkg::fwdSrc    fwdRtE,
	output hazardPkg::fwdSrc    fwdRtM
);

	////////////////////////////////////////////////////////////
	// Match helpers
	////////////////////////////////////////////////////////////

	// Register 0 is never a real dependency
	function automatic logic isRead(input mipsIsaPkg::regNum r,
			input hazardPkg::tickCount tuse);
		return (r != '0) && (tuse != hazardPkg::tuseNone);
	endfunction

	// Writer holds the value right now
	function automatic logic isReady(input mipsIsaPkg::regNum r,
			input hazardPkg::hazardRec rec);
		return (rec.dest == r) && (rec.tnew == hazardPkg::tnewNow);
	endfunction

	// Writer cannot deliver before the reader needs it
	function automatic logic isLate(input mipsIsaPkg::regNum r,
			input hazardPkg::tickCount tuse, input hazardPkg::hazardRec rec);
		return (rec.dest == r) && (rec.tnew > tuse);
	endfunction

	// Nearest ready writer wins, E then M then W
	function automatic hazardPkg::fwdSrc pickSrc(input mipsIsaPkg::regNum r,
			input hazardPkg::tickCount tuse,
			input logic useE, input hazardPkg::hazardRec e,
			input logic useM, input hazardPkg::hazardRec m,
			input hazardPkg::hazardRec w);
		hazardPkg::fwdSrc src;
		src = hazardPkg::fwdNone;
		if (isRead(r, tuse)) begin
			if (useE && isReady(r, e)) begin
				src = hazardPkg::fwdE;
			end else if (useM && isReady(r, m)) begin
				src = hazardPkg::fwdM;
			end else if (isReady(r, w)) begin
				src = hazardPkg::fwdW;
			end
		end
		return src;
	endfunction

	logic                 stallRs;
	logic                 stallRt;
	hazardPkg::tickCount  tuseStoreM;

	////////////////////////////////////////////////////////////
	// Stall and select logic
	////////////////////////////////////////////////////////////

	always_comb begin
		stallRs = isRead(recD.rs, recD.tuseRs) &&
			(isLate(recD.rs, recD.tuseRs, recE) || isLate(recD.rs, recD.tuseRs, recM));
		stallRt = isRead(recD.rt, recD.tuseRt) &&
			(isLate(recD.rt, recD.tuseRt, recE) || isLate(recD.rt, recD.tuseRt, recM));
		stall = stallRs || stallRt;

		// D readers see every stage ahead
		fwdRsD = pickSrc(recD.rs, recD.tuseRs, 1'b1, recE, 1'b1, recM, recW);
		fwdRtD = pickSrc(recD.rt, recD.tuseRt, 1'b1, recE, 1'b1, recM, recW);

		// E readers only M and W
		fwdRsE = pickSrc(recE.rs, recE.tuseRs, 1'b0, recE, 1'b1, recM, recW);
		fwdRtE = pickSrc(recE.rt, recE.tuseRt, 1'b0, recE, 1'b1, recM, recW);

		// Only store data is still consumed in M
		if (recM.tuseRt == hazardPkg::tuseStore) begin
			tuseStoreM = recM.tuseRt;
		end else begin
			tuseStoreM = hazardPkg::tuseNone;
		end
		fwdRtM = pickSrc(recM.rt, tuseStoreM, 1'b0, recE, 1'b0, recM, recW);
	end

endmodule

//--- design/hazardStagePipe.sv
`timescale 1ns/100ps

module hazardStagePipe (
	input  logic                clk,
	input  logic                rstN,
	input  logic                stall,
	input  hazardPkg::hazardRec recD,
	output hazardPkg::hazardRec recE,
	output hazardPkg::hazardRec recM,
	output hazardPkg::hazardRec recW
);

	// One stage closer to the result, never below zero
	function automatic hazardPkg::hazardRec ageRec(input hazardPkg::hazardRec rec);
		hazardPkg::hazardRec aged;
		aged = rec;
		if (rec.tnew != hazardPkg::tnewNow) begin
			aged.tnew = rec.tnew - 2'd1;
		end
		return aged;
	endfunction

	////////////////////////////////////////////////////////////
	// Stage registers
	////////////////////////////////////////////////////////////

	// Tnew from decode is already the E-stage value,
	// so aging starts on the E to M hop
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			recE <= hazardPkg::bubbleRec;
			recM <= hazardPkg::bubbleRec;
			recW <= hazardPkg::bubbleRec;
		end else begin
			// D holds under stall, so E gets an empty slot
			if (stall) begin
				recE <= hazardPkg::bubbleRec;
			end else begin
				recE <= recD;
			end
			recM <= ageRec(recE);
			recW <= ageRec(recM);
		end
	end

endmodule

//--- design/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
	input  logic             clk,
	input  logic             rstN,
	input  logic [31:0]      instrD,
	output logic             stall,
	output hazardPkg::fwdSrc fwdRsD,
	output hazardPkg::fwdSrc fwdRtD,
	output hazardPkg::fwdSrc fwdRsE,
	output hazardPkg::fwdSrc fwdRtE,
	output hazardPkg::fwdSrc fwdRtM
);

	hazardPkg::hazardRec recD;
	hazardPkg::hazardRec recE;
	hazardPkg::hazardRec recM;
	hazardPkg::hazardRec recW;

	// Classify the instruction sitting in D
	hazardDecode hazardDecode_i (
		.instr (instrD),
		.rec   (recD)
	);

	// Records for E, M and W
	hazardStagePipe hazardStagePipe_i (
		.clk   (clk),
		.rstN  (rstN),
		.stall (stall),
		.recD  (recD),
		.recE  (recE),
		.recM  (recM),
		.recW  (recW)
	);

	hazardResolve hazardResolve_i (
		.recD   (recD),
		.recE   (recE),
		.recM   (recM),
		.recW   (recW),
		.stall  (stall),
		.fwdRsD (fwdRsD),
		.fwdRtD (fwdRtD),
		.fwdRsE (fwdRsE),
		.fwdRtE (fwdRtE),
		.fwdRtM (fwdRtM)
	);

endmodule

//--- design/mipsIsaPkg.sv
package mipsIsaPkg;

	////////////////////////////////////////////////////////////
	// Register numbers
	////////////////////////////////////////////////////////////

	typedef logic [4:0] regNum;

	// Link register written by jal
	localparam regNum regRa = 5'd31;

	////////////////////////////////////////////////////////////
	// Primary opcodes, instr[31:26]
	////////////////////////////////////////////////////////////

	// Special group, decoded further by funct
	localparam logic [5:0] opR    = 6'b000000;

	// Jumps and branches
	localparam logic [5:0] opJ    = 6'b000010;
	localparam logic [5:0] opJal  = 6'b000011;
	localparam logic [5:0] opBeq  = 6'b000100;
	localparam logic [5:0] opBne  = 6'b000101;

	// Immediate arithmetic and logic
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri  = 6'b001101;
	localparam logic [5:0] opLui  = 6'b001111;

	// Loads
	localparam logic [5:0] opLb   = 6'b100000;
	localparam logic [5:0] opLh   = 6'b100001;
	localparam logic [5:0] opLw   = 6'b100011;

	// Stores
	localparam logic [5:0] opSb   = 6'b101000;
	localparam logic [5:0] opSh   = 6'b101001;
	localparam logic [5:0] opSw   = 6'b101011;

	////////////////////////////////////////////////////////////
	// Funct codes for opR, instr[5:0]
	////////////////////////////////////////////////////////////

	localparam logic [5:0] fnJr    = 6'b001000;

	// HI/LO moves
	localparam logic [5:0] fnMfhi  = 6'b010000;
	localparam logic [5:0] fnMthi  = 6'b010001;
	localparam logic [5:0] fnMflo  = 6'b010010;
	localparam logic [5:0] fnMtlo  = 6'b010011;

	// Multiply and divide
	localparam logic [5:0] fnMult  = 6'b011000;
	localparam logic [5:0] fnMultu = 6'b011001;
	localparam logic [5:0] fnDiv   = 6'b011010;
	localparam logic [5:0] fnDivu  = 6'b011011;

	// Register-register ALU
	localparam logic [5:0] fnAdd   = 6'b100000;
	localparam logic [5:0] fnSub   = 6'b100010;
	localparam logic [5:0] fnAnd   = 6'b100100;
	localparam logic [5:0] fnOr    = 6'b100101;
	localparam logic [5:0] fnSlt   = 6'b101010;
	localparam logic [5:0] fnSltu  = 6'b101011;

	////////////////////////////////////////////////////////////
	// Instruction word, R-type view
	////////////////////////////////////////////////////////////

	// I and J formats overlay the same bits, only the fields we need are named
	typedef struct packed {
		logic [5:0] op;
		regNum      rs;
		regNum      rt;
		regNum      rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instrFields;

endpackage

//--- project.f
design/mipsIsaPkg.sv
design/hazardPkg.sv
design/hazardDecode.sv
design/hazardStagePipe.sv
design/hazardResolve.sv
design/hazardUnit.sv
bench/hazardUnit_props.sv
bench/hazardUnitTb.sv
